// File: flist.f
+incdir+design
design/ram_req_pkg.sv
design/ram_data_pkg.sv
design/ram_cmd_decoder.sv
design/ram_bank_router.sv
design/ram_bank.sv
design/ram_resp_merger.sv
design/ram_model_top.sv
sim/ram_model_tb.sv

// File: sim/ram_model_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "ram_model_params.svh"

module ram_model_tb;

    localparam int NUM_BANKS  = `RAM_NUM_BANKS;
    localparam int BANK_WORDS = `RAM_BANK_WORDS;
    localparam int WORD_BITS  = $clog2(`RAM_BANK_WORDS);
    localparam int BANK_BITS  = $clog2(`RAM_NUM_BANKS);
    localparam int CMD_WORDS  = (`RAM_ADDR_WIDTH > 32) ? 3 : 2;
    localparam logic [1:0] FIXED = 2'd0;
    localparam logic [1:0] INCR  = 2'd1;

    logic        clk = 1'b0;
    logic        rst;
    logic        cmd_valid;
    logic        cmd_ready;
    logic [31:0] cmd_data;
    logic        wr_valid;
    logic        wr_ready;
    logic [31:0] wr_data;
    logic        resp_valid;
    logic        resp_ready;
    logic [31:0] resp_data;
    logic        idle;

    logic [31:0] lfsr = 32'd34;
    logic [31:0] cmd_q [$];
    logic [31:0] wr_q [$];
    logic [32:0] exp_q [$];             // Bit 32 marks the last word of a transaction.
    logic [31:0] ref_mem [NUM_BANKS*BANK_WORDS];
    int          cmd_taken = 0;
    int          wr_taken = 0;
    int          cmd_pos = 0;
    int          wr_pos = 0;
    int          pending = 0;
    int          mismatches = 0;
    int          other_errors = 0;
    int          cycles = 0;
    int          cycle_limit = 1000000;

    ram_model_top i_dut (
        .clk(clk), .rst(rst),
        .cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd_data(cmd_data),
        .wr_valid(wr_valid), .wr_ready(wr_ready), .wr_data(wr_data),
        .resp_valid(resp_valid), .resp_ready(resp_ready), .resp_data(resp_data),
        .idle(idle)
    );

    always #20 clk = ~clk;

    // Taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] bits;
        logic        fb;
        int          i;
        bits = '0;
        for (i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            bits = {bits[30:0], fb};
        end
        return bits;
    endfunction

    // Flat index of beat number beat, bank above word.
    function automatic int ref_index(input logic [63:0] addr, input logic [1:0] burst,
                                     input int beat);
        int word;
        int bank;
        word = int'(addr[2 +: WORD_BITS]);
        bank = int'(addr[2+WORD_BITS +: BANK_BITS]);
        if (burst != FIXED) word = (word + beat) % BANK_WORDS;
        return bank * BANK_WORDS + word;
    endfunction

    function automatic logic [31:0] ref_header(input logic [15:0] id, input logic [7:0] len,
                                               input logic write);
        return {id, len, 7'd0, write};
    endfunction

    task automatic add_cmd(input logic write, input logic [1:0] burst, input int bank,
                           input int word, input int beats);
        logic [63:0] addr;
        logic [15:0] id;
        logic [7:0]  len;
        logic [31:0] data;
        int          k;
        addr = 64'((bank * BANK_WORDS + word) * 4);
        id   = 16'(lfsr_bits(16));
        len  = 8'(beats - 1);
        cmd_q.push_back({id, len, 3'd2, burst, 2'b00, write});
        cmd_q.push_back(addr[31:0]);
        if (`RAM_ADDR_WIDTH > 32) cmd_q.push_back(addr[63:32]);
        exp_q.push_back({write, ref_header(id, len, write)});
        for (k = 0; k < beats; k++) begin
            if (write) begin
                data = lfsr_bits(32);
                wr_q.push_back(data);
                ref_mem[ref_index(addr, burst, k)] = data;
            end else begin
                exp_q.push_back({k == beats - 1, ref_mem[ref_index(addr, burst, k)]});
            end
        end
    endtask

    task automatic build_stimulus();
        int b;
        int w;
        int n;
        add_cmd(1'b1, INCR, 0, 5, 1);  // Single word write and read back.
        add_cmd(1'b0, INCR, 0, 5, 1);
        for (b = 0; b < NUM_BANKS; b++) begin
            for (w = 0; w < BANK_WORDS; w += 16) add_cmd(1'b1, INCR, b, w, 16);
        end
        for (n = 0; n < 24; n++) begin
            add_cmd(1'(lfsr_bits(1)), INCR, int'(lfsr_bits(BANK_BITS)),
                    int'(lfsr_bits(WORD_BITS)), int'(lfsr_bits(4)) + 1);
        end
        add_cmd(1'b1, FIXED, 1, 10, 4);
        add_cmd(1'b0, FIXED, 1, 10, 5);
        add_cmd(1'b0, INCR, 1, 9, 3);
        // Burst near the top of bank 2 wraps to its word 0.
        add_cmd(1'b1, INCR, 2 % NUM_BANKS, BANK_WORDS - 3, 8);
        add_cmd(1'b0, INCR, 2 % NUM_BANKS, BANK_WORDS - 4, 10);
        add_cmd(1'b0, INCR, 3 % NUM_BANKS, 0, 4);
        add_cmd(1'b0, INCR, 1, BANK_WORDS - 4, 4);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            mismatches++;
            $display("mismatch %s: got %h, expected %h at %0t", name, got, want, $time);
        end
    endtask

    task automatic report_counts();
        $display("Errors: %0d mismatches, %0d other failures", mismatches, other_errors);
    endtask

    task automatic drive_inputs();
        if (!(cmd_valid && cmd_pos == cmd_taken)) begin
            if (cmd_taken < cmd_q.size() && lfsr_bits(2) != 0) begin
                cmd_valid = 1'b1;
                cmd_data  = cmd_q[cmd_taken];
                cmd_pos   = cmd_taken;
            end else begin
                cmd_valid = 1'b0;
            end
        end
        if (!(wr_valid && wr_pos == wr_taken)) begin
            if (wr_taken < wr_q.size() && lfsr_bits(2) != 0) begin
                wr_valid = 1'b1;
                wr_data  = wr_q[wr_taken];
                wr_pos   = wr_taken;
            end else begin
                wr_valid = 1'b0;
            end
        end
        resp_ready = lfsr_bits(2) != 0;  // Stalls about one cycle in four.
    endtask

    always @(posedge clk) begin
        logic [32:0] exp_word;
        if (!rst) begin
            if (pending > 0 && idle) begin
                other_errors++;
                $display("idle is high while %0d transactions are pending at %0t",
                         pending, $time);
            end
            if (cmd_valid && cmd_ready) begin
                cmd_taken++;
                if (cmd_taken % CMD_WORDS == 0) pending++;
            end
            if (wr_valid && wr_ready) wr_taken++;
            if (resp_valid && resp_ready) begin
                if (exp_q.size() == 0) begin
                    other_errors++;
                    $display("response word %h arrived when none was expected", resp_data);
                end else begin
                    exp_word = exp_q.pop_front();
                    check_value("resp_data", resp_data, exp_word[31:0]);
                    if (exp_word[32]) pending--;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            other_errors++;
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            report_counts();
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin
        rst        = 1'b1;
        cmd_valid  = 1'b0;
        cmd_data   = '0;
        wr_valid   = 1'b0;
        wr_data    = '0;
        resp_ready = 1'b0;
        build_stimulus();
        cycle_limit = 40 * (cmd_q.size() + wr_q.size()) + 200;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        while (cmd_taken < cmd_q.size() || wr_taken < wr_q.size() || exp_q.size() != 0) begin
            @(negedge clk);
            drive_inputs();
        end
        cmd_valid  = 1'b0;
        wr_valid   = 1'b0;
        resp_ready = 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_value("idle", {31'd0, idle}, 32'd1);
        report_counts();
        if (mismatches == 0 && other_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: design/ram_model_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "ram_model_params.svh"

module ram_model_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        cmd_valid,
    output logic        cmd_ready,
    input  logic [31:0] cmd_data,
    input  logic        wr_valid,
    output logic        wr_ready,
    input  logic [31:0] wr_data,
    output logic        resp_valid,
    input  logic        resp_ready,
    output logic [31:0] resp_data,
    output logic        idle
);

    import ram_req_pkg::*;
    import ram_data_pkg::*;

    a_req_t                             req;
    a_req_t                             bank_req;
    w_beat_t                            bank_w;
    bank_resp_t                         bank_resp [`RAM_NUM_BANKS];
    logic [`RAM_NUM_BANKS-1:0]          bank_req_valid;
    logic [`RAM_NUM_BANKS-1:0]          bank_req_ready;
    logic [`RAM_NUM_BANKS-1:0]          bank_w_valid;
    logic [`RAM_NUM_BANKS-1:0]          bank_w_ready;
    logic [`RAM_NUM_BANKS-1:0]          bank_resp_valid;
    logic [`RAM_NUM_BANKS-1:0]          bank_resp_ready;
    logic [$clog2(`RAM_NUM_BANKS)-1:0]  ord_bank;
    logic                               req_valid;
    logic                               req_ready;
    logic                               ord_valid;
    logic                               ord_ready;
    logic                               dec_busy;
    logic                               rtr_busy;
    logic                               mrg_busy;

    ram_cmd_decoder i_decoder (
        .clk, .rst, .cmd_valid, .cmd_ready, .cmd_data,
        .req_valid, .req_ready, .req, .busy(dec_busy)
    );

    ram_bank_router i_router (
        .clk, .rst, .req_valid, .req_ready, .req,
        .bank_req_valid, .bank_req_ready, .bank_req,
        .wr_valid, .wr_ready, .wr_data, .bank_w_valid, .bank_w_ready, .bank_w,
        .ord_valid, .ord_ready, .ord_bank, .busy(rtr_busy)
    );

    for (genvar i = 0; i < `RAM_NUM_BANKS; i++) begin : g_bank
        ram_bank i_bank (
            .clk, .rst,
            .req_valid(bank_req_valid[i]), .req_ready(bank_req_ready[i]), .req(bank_req),
            .w_valid(bank_w_valid[i]), .w_ready(bank_w_ready[i]), .w(bank_w),
            .resp_valid(bank_resp_valid[i]), .resp_ready(bank_resp_ready[i]),
            .resp(bank_resp[i])
        );
    end

    ram_resp_merger i_merger (
        .clk, .rst, .ord_valid, .ord_ready, .ord_bank,
        .bank_resp_valid, .bank_resp_ready, .bank_resp,
        .resp_valid, .resp_ready, .resp_data, .busy(mrg_busy)
    );

    assign idle = !(dec_busy || rtr_busy || mrg_busy);

endmodule

`default_nettype wire

// File: design/ram_resp_merger.sv
`timescale 1ns/100ps
`default_nettype none

`include "ram_model_params.svh"

module ram_resp_merger (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              ord_valid,
    output logic                              ord_ready,
    input  logic [$clog2(`RAM_NUM_BANKS)-1:0] ord_bank,
    input  logic [`RAM_NUM_BANKS-1:0]         bank_resp_valid,
    output logic [`RAM_NUM_BANKS-1:0]         bank_resp_ready,
    input  ram_data_pkg::bank_resp_t          bank_resp [`RAM_NUM_BANKS],
    output logic                              resp_valid,
    input  logic                              resp_ready,
    output logic [31:0]                       resp_data,
    output logic                              busy
);

    import ram_data_pkg::*;

    localparam int BANK_BITS = $clog2(`RAM_NUM_BANKS);
    localparam int PTR_BITS  = $clog2(`RAM_ORDER_DEPTH);
    localparam logic [PTR_BITS:0] DEPTH = `RAM_ORDER_DEPTH;

    logic [BANK_BITS-1:0] ord_q [`RAM_ORDER_DEPTH];
    logic [BANK_BITS-1:0] head_bank;
    logic [PTR_BITS-1:0]  wr_ptr;
    logic [PTR_BITS-1:0]  rd_ptr;
    logic [PTR_BITS:0]    count;
    logic                 hdr_sent;
    logic                 show_hdr;
    logic                 consume;
    logic                 push;
    logic                 pop;
    bank_resp_t           head;

    assign head_bank  = ord_q[rd_ptr];
    assign head       = bank_resp[head_bank];
    assign show_hdr   = head.first && !hdr_sent;
    assign resp_valid = count != 0 && bank_resp_valid[head_bank];
    assign resp_data  = show_hdr ? {head.id, head.len, 7'd0, head.opcode} : head.data;

    // A write is header only, so its header word takes the bank response.
    assign consume = resp_valid && resp_ready && (!show_hdr || head.opcode == RESP_WRITE);
    assign bank_resp_ready = `RAM_NUM_BANKS'(count != 0 && resp_ready &&
                                             (!show_hdr || head.opcode == RESP_WRITE)) << head_bank;

    assign ord_ready = count != DEPTH;
    assign push      = ord_valid && ord_ready;
    assign pop       = consume && head.last;
    assign busy      = count != 0;

    always_ff @(posedge clk) begin
        if (push) ord_q[wr_ptr] <= ord_bank;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            hdr_sent <= 1'b0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
            if (consume) begin
                hdr_sent <= 1'b0;
            end else if (resp_valid && resp_ready && show_hdr) begin
                hdr_sent <= 1'b1;  // Read header out, data next.
            end
        end
    end

endmodule

`default_nettype wire

// File: design/ram_bank.sv
`timescale 1ns/100ps
`default_nettype none

`include "ram_model_params.svh"

module ram_bank (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req_valid,
    output logic                     req_ready,
    input  ram_req_pkg::a_req_t      req,
    input  logic                     w_valid,
    output logic                     w_ready,
    input  ram_data_pkg::w_beat_t    w,
    output logic                     resp_valid,
    input  logic                     resp_ready,
    output ram_data_pkg::bank_resp_t resp
);

    import ram_req_pkg::*;
    import ram_data_pkg::*;

    localparam int WORD_BITS = $clog2(`RAM_BANK_WORDS);

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_WRITE = 2'd1,
        ST_READ  = 2'd2,
        ST_WRESP = 2'd3
    } bank_state_e;

    logic [31:0]          mem [`RAM_BANK_WORDS];
    bank_state_e          state;
    logic [WORD_BITS-1:0] idx;
    logic [WORD_BITS-1:0] next_idx;
    logic [WORD_BITS-1:0] rd_idx;
    logic [7:0]           cnt;
    logic [7:0]           len_q;
    logic [15:0]          id_q;
    burst_e               burst_q;
    logic [31:0]          rdata;
    logic                 req_fire;
    logic                 w_fire;
    logic                 resp_fire;
    logic                 rd_en;

    assign req_ready  = state == ST_IDLE;
    assign w_ready    = state == ST_WRITE;
    assign resp_valid = state == ST_READ || state == ST_WRESP;
    assign req_fire   = req_valid && req_ready;
    assign w_fire     = w_valid && w_ready;
    assign resp_fire  = resp_valid && resp_ready;

    // WRAP runs as INCR, wrapping inside the bank.
    assign next_idx = burst_q == FIXED ? idx : idx + 1'b1;
    assign rd_idx   = req_fire ? req.addr[2 +: WORD_BITS] : next_idx;
    assign rd_en    = (req_fire && !req.write) || (state == ST_READ && resp_fire && cnt != len_q);

    always_ff @(posedge clk) begin
        if (w_fire) mem[idx] <= w.data;
        if (rd_en) rdata <= mem[rd_idx];  // Holds while stalled.
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE:  if (req_fire) state <= req.write ? ST_WRITE : ST_READ;
                ST_WRITE: if (w_fire && w.last) state <= ST_WRESP;
                ST_READ:  if (resp_fire && cnt == len_q) state <= ST_IDLE;
                ST_WRESP: if (resp_fire) state <= ST_IDLE;
                default:  state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            idx     <= req.addr[2 +: WORD_BITS];
            cnt     <= '0;
            len_q   <= req.len;
            id_q    <= req.id;
            burst_q <= req.burst;
        end else if (w_fire || (state == ST_READ && resp_fire)) begin
            idx <= next_idx;
            cnt <= cnt + 8'd1;
        end
    end

    always_comb begin
        resp.opcode = state == ST_WRESP ? RESP_WRITE : RESP_READ;
        resp.id     = id_q;
        resp.len    = len_q;
        resp.data   = rdata;
        resp.first  = state == ST_WRESP || cnt == 8'd0;
        resp.last   = state == ST_WRESP || cnt == len_q;
    end

endmodule

`default_nettype wire

// File: design/ram_bank_router.sv
`timescale 1ns/100ps
`default_nettype none

`include "ram_model_params.svh"

module ram_bank_router (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   req_valid,
    output logic                                   req_ready,
    input  ram_req_pkg::a_req_t                    req,
    output logic [`RAM_NUM_BANKS-1:0]              bank_req_valid,
    input  logic [`RAM_NUM_BANKS-1:0]              bank_req_ready,
    output ram_req_pkg::a_req_t                    bank_req,
    input  logic                                   wr_valid,
    output logic                                   wr_ready,
    input  logic [31:0]                            wr_data,
    output logic [`RAM_NUM_BANKS-1:0]              bank_w_valid,
    input  logic [`RAM_NUM_BANKS-1:0]              bank_w_ready,
    output ram_data_pkg::w_beat_t                  bank_w,
    output logic                                   ord_valid,
    input  logic                                   ord_ready,
    output logic [$clog2(`RAM_NUM_BANKS)-1:0]      ord_bank,
    output logic                                   busy
);

    localparam int BANK_BITS = $clog2(`RAM_NUM_BANKS);
    localparam int WORD_BITS = $clog2(`RAM_BANK_WORDS);
    localparam int PTR_BITS  = $clog2(`RAM_ORDER_DEPTH);
    localparam logic [PTR_BITS:0] DEPTH = `RAM_ORDER_DEPTH;

    typedef struct packed {
        logic [BANK_BITS-1:0] bank;
        logic [7:0]           len;
    } wq_entry_t;

    wq_entry_t            wq [`RAM_ORDER_DEPTH];
    wq_entry_t            wq_head;
    logic [PTR_BITS-1:0]  wq_wr_ptr;
    logic [PTR_BITS-1:0]  wq_rd_ptr;
    logic [PTR_BITS:0]    wq_count;
    logic [7:0]           w_cnt;
    logic [BANK_BITS-1:0] sel;
    logic                 room;
    logic                 req_fire;
    logic                 w_fire;
    logic                 w_last;
    logic                 wq_push;
    logic                 wq_pop;

    // Bank bits sit just above the word index.
    assign sel  = req.addr[2+WORD_BITS +: BANK_BITS];
    assign room = !req.write || wq_count != DEPTH;

    assign ord_valid      = req_valid && bank_req_ready[sel] && room;
    assign ord_bank       = sel;
    assign req_ready      = bank_req_ready[sel] && ord_ready && room;
    assign bank_req_valid = `RAM_NUM_BANKS'(req_valid && ord_ready && room) << sel;
    assign bank_req       = req;
    assign req_fire       = req_valid && req_ready;

    // Write words go to the oldest pending write.
    assign wq_head      = wq[wq_rd_ptr];
    assign w_last       = w_cnt == wq_head.len;
    assign wr_ready     = wq_count != 0 && bank_w_ready[wq_head.bank];
    assign bank_w_valid = `RAM_NUM_BANKS'(wr_valid && wq_count != 0) << wq_head.bank;
    assign bank_w       = '{data: wr_data, last: w_last};
    assign w_fire       = wr_valid && wr_ready;

    assign wq_push = req_fire && req.write;
    assign wq_pop  = w_fire && w_last;
    assign busy    = wq_count != 0;

    always_ff @(posedge clk) begin
        if (wq_push) wq[wq_wr_ptr] <= '{bank: sel, len: req.len};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wq_wr_ptr <= '0;
            wq_rd_ptr <= '0;
            wq_count  <= '0;
            w_cnt     <= '0;
        end else begin
            if (wq_push) wq_wr_ptr <= wq_wr_ptr + 1'b1;
            if (wq_pop) wq_rd_ptr <= wq_rd_ptr + 1'b1;
            if (wq_push && !wq_pop) begin
                wq_count <= wq_count + 1'b1;
            end else if (wq_pop && !wq_push) begin
                wq_count <= wq_count - 1'b1;
            end
            if (w_fire) w_cnt <= w_last ? 8'd0 : w_cnt + 8'd1;
        end
    end

endmodule

`default_nettype wire

// File: design/ram_cmd_decoder.sv
`timescale 1ns/100ps
`default_nettype none

`include "ram_model_params.svh"

module ram_cmd_decoder (
    input  logic                clk,
    input  logic                rst,
    input  logic                cmd_valid,
    output logic                cmd_ready,
    input  logic [31:0]         cmd_data,
    output logic                req_valid,
    input  logic                req_ready,
    output ram_req_pkg::a_req_t req,
    output logic                busy
);

    import ram_req_pkg::*;

    localparam bit ADDR_32 = `RAM_ADDR_WIDTH <= 32;

    dec_state_e state;
    dec_state_e state_next;
    logic       cmd_fire;
    logic       req_fire;

    assign cmd_fire = cmd_valid && cmd_ready;
    assign req_fire = req_valid && req_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (cmd_fire) state_next = HEAD;
            end
            HEAD: begin
                if (cmd_fire) state_next = ADDR_1;
            end
            ADDR_1: begin
                if (ADDR_32 ? req_fire : cmd_fire) begin
                    state_next = ADDR_32 ? IDLE : ADDR_2;
                end
            end
            ADDR_2: begin
                if (req_fire) state_next = IDLE;
            end
            default: state_next = IDLE;
        endcase
    end

    // Low while a request waits for the router.
    assign cmd_ready = state == IDLE || state == HEAD || (state == ADDR_1 && !ADDR_32);
    assign req_valid = ADDR_32 ? state == ADDR_1 : state == ADDR_2;
    assign busy      = state != IDLE;

    always_ff @(posedge clk) begin
        if (cmd_fire) begin
            case (state)
                IDLE: begin
                    req.id    <= cmd_data[31:16];
                    req.len   <= cmd_data[15:8];
                    req.size  <= cmd_data[7:5];
                    req.burst <= burst_e'(cmd_data[4:3]);
                    req.write <= cmd_data[0];
                end
                HEAD: begin
                    req.addr <= `RAM_ADDR_WIDTH'(cmd_data);  // Low word.
                end
                ADDR_1: begin
                    req.addr <= `RAM_ADDR_WIDTH'({cmd_data, req.addr[31:0]});
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/ram_data_pkg.sv
`default_nettype none

package ram_data_pkg;

    typedef enum logic {
        RESP_READ  = 1'b0,
        RESP_WRITE = 1'b1
    } resp_op_e;

    typedef struct packed {
        logic [31:0] data;
        logic        last;
    } w_beat_t;

    typedef struct packed {
        resp_op_e    opcode;
        logic [15:0] id;
        logic [7:0]  len;
        logic [31:0] data;   // Read data, don't care for writes.
        logic        first;
        logic        last;
    } bank_resp_t;

endpackage

`default_nettype wire

// File: design/ram_req_pkg.sv
`default_nettype none

`include "ram_model_params.svh"

package ram_req_pkg;

    // Burst field of the command header, bits 4 to 3.
    typedef enum logic [1:0] {
        FIXED = 2'd0,
        INCR  = 2'd1,
        WRAP  = 2'd2
    } burst_e;

    // IDLE takes the header, HEAD the low address word.
    // ADDR_1 takes the high word or presents the request, ADDR_2 presents it.
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        HEAD   = 2'd1,
        ADDR_1 = 2'd2,
        ADDR_2 = 2'd3
    } dec_state_e;

    typedef struct packed {
        logic                       write;
        logic [`RAM_ADDR_WIDTH-1:0] addr;  // Byte address.
        logic [15:0]                id;
        logic [7:0]                 len;   // Beats minus one.
        logic [2:0]                 size;
        burst_e                     burst;
    } a_req_t;

endpackage

`default_nettype wire

// File: design/ram_model_params.svh
`ifndef RAM_MODEL_PARAMS_SVH
`define RAM_MODEL_PARAMS_SVH

// Address width in bits, 32 or 64.
`define RAM_ADDR_WIDTH 32

// Number of banks, a power of two.
`define RAM_NUM_BANKS 4

// 32-bit words per bank, a power of two.
`define RAM_BANK_WORDS 64

// Transactions in flight, a power of two.
`define RAM_ORDER_DEPTH 4

`endif
